// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module decimatingFilterTb -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
rtl/dfPkg.sv
rtl/dfCtrlIf.sv
rtl/dfRegs.sv
rtl/halfbandDecimator.sv
rtl/cicDecimator.sv
rtl/compensationFir.sv
rtl/decimatingFilter.sv
verification/clockGen.sv
verification/decimatingFilterTb.sv

// ==== rtl/cicDecimator.sv ====
// Multi-stage CIC decimator with programmable ratio, output shift and bypass.
`timescale 1ns/1ps
`default_nettype none

module cicDecimator #(
    parameter int CIC_STAGES = 3
) (
    input  wire                 busClk,
    input  wire                 rstN,
    dfCtrlIf.datapath           ctrl,
    input  wire dfPkg::sampleT  inSample,
    input  wire                 inValid,
    output dfPkg::sampleT       outSample,
    output logic                outValid
);

    import dfPkg::*;

    cicAccT integ [CIC_STAGES];
    cicAccT integNext [CIC_STAGES];
    cicAccT combDelay [CIC_STAGES];
    cicAccT combStage [CIC_STAGES+1];   // comb input, then one entry per stage.

    cicDecT count;
    cicDecT ratio;
    logic   wrap;
    sampleT decimated;

    // ##############################
    // integrators and combs.
    always_comb begin
        ratio = (ctrl.cicDecimation == '0) ? cicDecT'(1) : ctrl.cicDecimation;
        wrap  = (count >= cicDecT'(ratio - 1'b1));

        // integrator chain sees the incoming sample this cycle.
        integNext[0] = integ[0] + cicAccT'(inSample);
        for (int k = 1; k < CIC_STAGES; k++) begin
            integNext[k] = integ[k] + integNext[k-1];
        end

        combStage[0] = integNext[CIC_STAGES-1];
        for (int k = 0; k < CIC_STAGES; k++) begin
            combStage[k+1] = combStage[k] - combDelay[k];
        end

        decimated = saturate(combStage[CIC_STAGES] >>> ctrl.cicShift);
    end

    // ##############################
    // state update.
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            count    <= '0;
            outValid <= 1'b0;
            for (int k = 0; k < CIC_STAGES; k++) begin
                integ[k]     <= '0;
                combDelay[k] <= '0;
            end
        end else begin
            outValid <= inValid && (ctrl.bypassCic || wrap);
            if (inValid && !ctrl.bypassCic) begin
                count <= wrap ? '0 : cicDecT'(count + 1'b1);
                for (int k = 0; k < CIC_STAGES; k++) begin
                    integ[k] <= integNext[k];
                end
                // combs run at the decimated rate.
                if (wrap) begin
                    for (int k = 0; k < CIC_STAGES; k++) begin
                        combDelay[k] <= combStage[k];
                    end
                end
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (inValid && (ctrl.bypassCic || wrap)) begin
            outSample <= ctrl.bypassCic ? inSample : decimated;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/compensationFir.sv ====
// Symmetric 5-tap compensation FIR at the output rate, with bypass.
`timescale 1ns/1ps
`default_nettype none

module compensationFir (
    input  wire                 busClk,
    input  wire                 rstN,
    input  wire                 bypass,
    input  wire dfPkg::sampleT  inSample,
    input  wire                 inValid,
    output dfPkg::sampleT       outSample,
    output logic                outValid
);

    import dfPkg::*;

    localparam int ACC_W = 24;

    localparam logic signed [ACC_W-1:0] COEF_EDGE   = ACC_W'(FIR_COEF[0]);
    localparam logic signed [ACC_W-1:0] COEF_NEAR   = ACC_W'(FIR_COEF[1]);
    localparam logic signed [ACC_W-1:0] COEF_CENTER = ACC_W'(FIR_COEF[2]);

    sampleT history [4];   // taps 1 to 4.

    logic signed [ACC_W-1:0] acc;
    sampleT                  filtered;

    // fold the mirrored taps before multiplying.
    always_comb begin
        acc = (ACC_W'(inSample) + ACC_W'(history[3])) * COEF_EDGE
            + (ACC_W'(history[0]) + ACC_W'(history[2])) * COEF_NEAR
            + ACC_W'(history[1]) * COEF_CENTER;
        filtered = saturate(cicAccT'(acc >>> FIR_NORM_SHIFT));
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            for (int k = 0; k < 4; k++) begin
                history[k] <= '0;
            end
        end else begin
            outValid <= inValid;   // one out per one in.
            if (inValid) begin
                history[0] <= inSample;
                for (int k = 1; k < 4; k++) begin
                    history[k] <= history[k-1];
                end
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (inValid) begin
            outSample <= bypass ? inSample : filtered;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decimatingFilter.sv ====
// Decimating filter top level with register block and four-stage filter chain.
`timescale 1ns/1ps
`default_nettype none

module decimatingFilter #(
    parameter dfPkg::regAddrT REG_BASE   = '0,
    parameter int             CIC_STAGES = 3
) (
    input  wire                  busClk,
    input  wire                  rstN,

    // register bus.
    input  wire dfPkg::regAddrT  addr,
    input  wire dfPkg::busDataT  dataIn,
    output dfPkg::busDataT       dataOut,
    input  wire                  cs,
    input  wire                  wr0,
    input  wire                  wr1,

    // sample stream.
    input  wire dfPkg::sampleT   inSample,
    input  wire                  inValid,
    output dfPkg::sampleT        outSample,
    output logic                 outValid
);

    import dfPkg::*;

    sampleT hb0Sample;
    logic   hb0Valid;
    sampleT cicSample;
    logic   cicValid;
    sampleT hb1Sample;
    logic   hb1Valid;

    dfCtrlIf ctrlBus ();

    // ##############################
    // control.
    dfRegs #(
        .REG_BASE (REG_BASE)
    ) regsBlock (
        .busClk  (busClk),
        .rstN    (rstN),
        .addr    (addr),
        .dataIn  (dataIn),
        .cs      (cs),
        .wr0     (wr0),
        .wr1     (wr1),
        .dataOut (dataOut),
        .ctrl    (ctrlBus.regs)
    );

    // ##############################
    // chain: hb0, cic, hb1, fir.
    halfbandDecimator hb0Stage (
        .busClk    (busClk),
        .rstN      (rstN),
        .bypass    (ctrlBus.bypassHb0),
        .inSample  (inSample),
        .inValid   (inValid),
        .outSample (hb0Sample),
        .outValid  (hb0Valid)
    );

    cicDecimator #(
        .CIC_STAGES (CIC_STAGES)
    ) cicStage (
        .busClk    (busClk),
        .rstN      (rstN),
        .ctrl      (ctrlBus.datapath),
        .inSample  (hb0Sample),
        .inValid   (hb0Valid),
        .outSample (cicSample),
        .outValid  (cicValid)
    );

    halfbandDecimator hb1Stage (
        .busClk    (busClk),
        .rstN      (rstN),
        .bypass    (ctrlBus.bypassHb1),
        .inSample  (cicSample),
        .inValid   (cicValid),
        .outSample (hb1Sample),
        .outValid  (hb1Valid)
    );

    compensationFir firStage (
        .busClk    (busClk),
        .rstN      (rstN),
        .bypass    (ctrlBus.bypassFir),
        .inSample  (hb1Sample),
        .inValid   (hb1Valid),
        .outSample (outSample),
        .outValid  (outValid)
    );

endmodule

`default_nettype wire

// ==== rtl/dfCtrlIf.sv ====
// Configuration bundle from the register block to the filter stages.
`timescale 1ns/1ps
`default_nettype none

interface dfCtrlIf;

    import dfPkg::*;

    logic     bypassHb0;
    logic     bypassCic;
    logic     bypassHb1;
    logic     bypassFir;
    cicDecT   cicDecimation;   // decimation ratio R.
    cicShiftT cicShift;        // right shift after the combs.

    // driven by the register block.
    modport regs (
        output bypassHb0,
        output bypassCic,
        output bypassHb1,
        output bypassFir,
        output cicDecimation,
        output cicShift
    );

    // stages pick out their own fields.
    modport datapath (
        input bypassHb0,
        input bypassCic,
        input bypassHb1,
        input bypassFir,
        input cicDecimation,
        input cicShift
    );

endinterface

`default_nettype wire

// ==== rtl/dfPkg.sv ====
// Shared types, register map and fixed filter constants of the decimating filter.
`default_nettype none

package dfPkg;

    typedef logic signed [15:0] sampleT;
    typedef logic [12:0]        regAddrT;
    typedef logic [31:0]        busDataT;
    typedef logic [14:0]        cicDecT;
    typedef logic [5:0]         cicShiftT;
    typedef logic signed [63:0] cicAccT;   // 16 bits in, plus 3 x 15 bits of growth.
    typedef logic signed [7:0]  coefT;

    // ##############################
    // register map, offsets from REG_BASE.
    localparam regAddrT DF_CONTROL        = 13'h000;
    localparam regAddrT DF_CIC_DECIMATION = 13'h004;
    localparam regAddrT DF_CIC_SHIFT      = 13'h008;

    localparam logic [3:0] CTRL_RESET       = 4'hF;   // every stage bypassed.
    localparam cicDecT     DECIMATION_RESET = 15'd1;
    localparam cicShiftT   SHIFT_RESET      = 6'd0;

    // ##############################
    // fixed taps, each set sums to 32.
    localparam coefT HB_COEF [7] = '{-8'sd1, 8'sd0, 8'sd9, 8'sd16, 8'sd9, 8'sd0, -8'sd1};
    localparam int   HB_NORM_SHIFT = 5;
    localparam coefT FIR_COEF [5] = '{-8'sd2, 8'sd4, 8'sd28, 8'sd4, -8'sd2};
    localparam int   FIR_NORM_SHIFT = 5;

    localparam cicAccT SAMPLE_MAX = 64'sd32767;
    localparam cicAccT SAMPLE_MIN = -64'sd32768;

    // clamp a wide signed value into the sample range.
    function automatic sampleT saturate(input cicAccT value);
        if (value > SAMPLE_MAX) return 16'sh7FFF;
        if (value < SAMPLE_MIN) return 16'sh8000;
        return sampleT'(value);
    endfunction

endpackage

`default_nettype wire

// ==== rtl/dfRegs.sv ====
// Configuration registers of the decimating filter on the chip-select bus.
`timescale 1ns/1ps
`default_nettype none

module dfRegs #(
    parameter dfPkg::regAddrT REG_BASE = '0
) (
    input  wire                  busClk,
    input  wire                  rstN,
    input  wire dfPkg::regAddrT  addr,
    input  wire dfPkg::busDataT  dataIn,
    input  wire                  cs,
    input  wire                  wr0,
    input  wire                  wr1,
    output dfPkg::busDataT       dataOut,
    dfCtrlIf.regs                ctrl
);

    import dfPkg::*;

    logic [3:0] ctrlBits;     // bypass bits, hb0 in bit 0.
    cicDecT     decimation;
    cicShiftT   shift;

    regAddrT    offset;
    logic       inWindow;
    logic       selControl;
    logic       selDecimation;
    logic       selShift;

    // ##############################
    // address decode.
    assign offset   = addr - REG_BASE;
    assign inWindow = (addr >= REG_BASE);

    assign selControl    = cs && inWindow && (offset == DF_CONTROL);
    assign selDecimation = cs && inWindow && (offset == DF_CIC_DECIMATION);
    assign selShift      = cs && inWindow && (offset == DF_CIC_SHIFT);

    // ##############################
    // byte-lane writes.
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            ctrlBits   <= CTRL_RESET;
            decimation <= DECIMATION_RESET;
            shift      <= SHIFT_RESET;
        end else begin
            // lane 0 covers all of control and shift.
            if (wr0) begin
                if (selControl) begin
                    ctrlBits <= dataIn[3:0];
                end
                if (selDecimation) begin
                    decimation[7:0] <= dataIn[7:0];
                end
                if (selShift) begin
                    shift <= dataIn[5:0];
                end
            end
            if (wr1 && selDecimation) begin
                decimation[14:8] <= dataIn[14:8];   // ratio spills into lane 1.
            end
        end
    end

    // ##############################
    // readback, zero fill and zero when idle.
    always_comb begin
        dataOut = '0;
        if (selControl) begin
            dataOut = {28'h0, ctrlBits};
        end else if (selDecimation) begin
            dataOut = {17'h0, decimation};
        end else if (selShift) begin
            dataOut = {26'h0, shift};
        end
    end

    assign ctrl.bypassHb0     = ctrlBits[0];
    assign ctrl.bypassCic     = ctrlBits[1];
    assign ctrl.bypassHb1     = ctrlBits[2];
    assign ctrl.bypassFir     = ctrlBits[3];
    assign ctrl.cicDecimation = decimation;
    assign ctrl.cicShift      = shift;

endmodule

`default_nettype wire

// ==== rtl/halfbandDecimator.sv ====
// Halfband low-pass filter that decimates by two, with a bypass path.
`timescale 1ns/1ps
`default_nettype none

module halfbandDecimator (
    input  wire                 busClk,
    input  wire                 rstN,
    input  wire                 bypass,
    input  wire dfPkg::sampleT  inSample,
    input  wire                 inValid,
    output dfPkg::sampleT       outSample,
    output logic                outValid
);

    import dfPkg::*;

    localparam int ACC_W = 24;

    localparam logic signed [ACC_W-1:0] COEF_OUTER  = ACC_W'(HB_COEF[0]);
    localparam logic signed [ACC_W-1:0] COEF_INNER  = ACC_W'(HB_COEF[2]);
    localparam logic signed [ACC_W-1:0] COEF_CENTER = ACC_W'(HB_COEF[3]);

    // inSample is tap 0, history holds taps 1 to 6.
    sampleT history [6];
    logic   phase;                // high on every second sample.

    logic signed [ACC_W-1:0] pairOuter;
    logic signed [ACC_W-1:0] pairInner;
    logic signed [ACC_W-1:0] center;
    logic signed [ACC_W-1:0] acc;
    sampleT                  filtered;

    // taps 1 and 5 are zero and skipped.
    always_comb begin
        pairOuter = ACC_W'(inSample) + ACC_W'(history[5]);
        pairInner = ACC_W'(history[1]) + ACC_W'(history[3]);
        center    = ACC_W'(history[2]);
        acc       = pairOuter * COEF_OUTER
                  + pairInner * COEF_INNER
                  + center * COEF_CENTER;
        filtered  = saturate(cicAccT'(acc >>> HB_NORM_SHIFT));   // truncating.
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            phase    <= 1'b0;
            outValid <= 1'b0;
            for (int k = 0; k < 6; k++) begin
                history[k] <= '0;
            end
        end else begin
            outValid <= inValid && (bypass || phase);
            if (inValid) begin
                phase      <= ~phase;
                history[0] <= inSample;
                for (int k = 1; k < 6; k++) begin
                    history[k] <= history[k-1];
                end
            end
        end
    end

    // payload only.
    always_ff @(posedge busClk) begin
        if (inValid && (bypass || phase)) begin
            outSample <= bypass ? inSample : filtered;
        end
    end

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
// Testbench clock and power-on reset source for the decimating filter.
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic busClk,
    output logic rstN
);

    initial begin
        busClk = 1'b0;
        forever #(PERIOD / 2) busClk = ~busClk;
    end

    // release just after an edge.
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge busClk);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/decimatingFilterTb.sv ====
// Testbench for the decimating filter, driven by the register and stream test file.
`timescale 1ns/1ps
`default_nettype none

module decimatingFilterTb;

    import dfPkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int STAGE_COUNT = 4;   // one register per stage on every path.

    // one parsed line, columns as in the test file.
    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] col1;
        logic [31:0] col2;
        logic [31:0] col3;
        logic [31:0] col4;
        logic [31:0] col5;
    } testLineT;

    logic     busClk;
    logic     rstN;
    regAddrT  addr;
    busDataT  dataIn;
    busDataT  dataOut;
    logic     cs;
    logic     wr0;
    logic     wr1;
    sampleT   inSample;
    logic     inValid;
    sampleT   outSample;
    logic     outValid;

    testLineT    tests [$];
    sampleT      outQ [$];
    logic [31:0] rng;
    int          budgetCycles;

    clockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) clockSource (
        .busClk (busClk),
        .rstN   (rstN)
    );

    decimatingFilter uut (
        .busClk    (busClk),
        .rstN      (rstN),
        .addr      (addr),
        .dataIn    (dataIn),
        .dataOut   (dataOut),
        .cs        (cs),
        .wr0       (wr0),
        .wr1       (wr1),
        .inSample  (inSample),
        .inValid   (inValid),
        .outSample (outSample),
        .outValid  (outValid)
    );

    // ##############################
    // failure reporting and compares.
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic checkBus(input string name, input busDataT got, input busDataT expected);
        if (got !== expected) begin
            abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    task automatic checkSample(input string name, input sampleT got, input sampleT expected);
        if (got !== expected) begin
            abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    task automatic checkCount(input string name, input int got, input int expected);
        if (got != expected) begin
            abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ##############################
    // test file and watchdog budget.
    task automatic loadTests();
        int          fd;
        int          busOps;
        int          samples;
        string       line;
        string       rest;
        logic [31:0] c1, c2, c3, c4, c5;
        testLineT    entry;
        busOps  = 0;
        samples = 0;
        fd = $fopen("verification/dfTests.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open the test file verification/dfTests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 2 && line.getc(0) != "#") begin
                rest = line.substr(2, line.len() - 1);
                {c1, c2, c3, c4, c5} = '0;
                entry.kind = line.getc(0);
                case (entry.kind)
                    "S": void'($sscanf(rest, "%h %d %d %h %d", c1, c2, c3, c4, c5));
                    "P": void'($sscanf(rest, "%h %d", c1, c2));
                    default: void'($sscanf(rest, "%h %h %h", c1, c2, c3));
                endcase
                entry.col1 = c1;
                entry.col2 = c2;
                entry.col3 = c3;
                entry.col4 = c4;
                entry.col5 = c5;
                if (entry.kind == "S" || entry.kind == "P") begin
                    samples += int'(c2);
                end else begin
                    busOps++;
                end
                tests.push_back(entry);
            end
        end
        $fclose(fd);
        budgetCycles = 2 * (20 * busOps + 3 * samples);
    endtask

    // ##############################
    // bus and stream drivers.
    task automatic writeReg(input regAddrT a, input busDataT d, input logic [1:0] lanes);
        @(posedge busClk);
        #1;
        addr   = a;
        dataIn = d;
        cs     = 1'b1;
        wr0    = lanes[0];
        wr1    = lanes[1];
        @(posedge busClk);   // register takes the lanes here.
        #1;
        cs  = 1'b0;
        wr0 = 1'b0;
        wr1 = 1'b0;
    endtask

    task automatic readReg(input regAddrT a, input logic select, input busDataT expected);
        @(posedge busClk);
        #1;
        addr = a;
        cs   = select;
        @(negedge busClk);
        checkBus("dataOut", dataOut, expected);
    endtask

    // step 0 gives a dc level, step 1 a ramp.
    task automatic runStream(input sampleT first, input int step, input int count);
        int sent;
        sent = 0;
        outQ.delete();
        while (sent < count) begin
            @(posedge busClk);
            #1;
            rng = xorshift(rng);
            inValid = (rng[1:0] != 2'b00);   // roughly one gap in four.
            if (inValid) begin
                inSample = sampleT'(int'(first) + step * sent);
                sent++;
            end
        end
        @(posedge busClk);
        #1;
        inValid = 1'b0;
        repeat (STAGE_COUNT) @(posedge busClk);
        @(negedge busClk);
    endtask

    always @(negedge busClk) begin
        if (rstN && outValid) begin
            outQ.push_back(outSample);
        end
    end

    initial begin
        wait (budgetCycles > 0);
        #(budgetCycles * CLK_PERIOD);
        abortRun("timeout, outputs stopped");
    end

    // ##############################
    // main sequence.
    initial begin
        addr         = '0;
        dataIn       = '0;
        cs           = 1'b0;
        wr0          = 1'b0;
        wr1          = 1'b0;
        inSample     = '0;
        inValid      = 1'b0;
        rng          = 32'h7912;
        budgetCycles = 0;
        loadTests();
        wait (rstN === 1'b1);
        foreach (tests[i]) begin
            case (tests[i].kind)
                "W": writeReg(regAddrT'(tests[i].col1), tests[i].col2, tests[i].col3[1:0]);
                "R": readReg(regAddrT'(tests[i].col1), tests[i].col2[0], tests[i].col3);
                "S": begin
                    runStream(sampleT'(tests[i].col1), 0, int'(tests[i].col2));
                    checkCount("output count", outQ.size(), int'(tests[i].col3));
                    for (int k = int'(tests[i].col5); k < outQ.size(); k++) begin
                        checkSample("outSample", outQ[k], sampleT'(tests[i].col4));
                    end
                end
                "P": begin
                    runStream(sampleT'(tests[i].col1), 1, int'(tests[i].col2));
                    checkCount("output count", outQ.size(), int'(tests[i].col2));
                    for (int k = 0; k < outQ.size(); k++) begin
                        checkSample("outSample", outQ[k], sampleT'(int'(tests[i].col1) + k));
                    end
                end
                default: abortRun("unknown line kind in the test file");
            endcase
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/dfTests.txt ====
# W address data lanes (bit 0 wr0, bit 1 wr1), hex.  R address cs expected, hex.
# S dc(hex) inputs outputs(dec) settled(hex) unchecked-leading(dec).  P first(hex) inputs(dec).
R 0000 1 0000000F
R 0004 1 00000001
R 0008 1 00000000
R 000C 1 00000000
R 1F00 1 00000000
R 0004 0 00000000
P 0100 40
W 0004 00007F22 2
R 0004 1 00007F01
W 0004 0000AA04 1
R 0004 1 00007F04
W 0000 FFFFFFF5 1
R 0000 1 00000005
W 0000 00000F00 2
R 0000 1 00000005
W 0004 00000002 3
W 0008 00000003 1
W 0000 00000008 1
R 0008 1 00000003
S 0800 128 16 0800 8
W 0000 00000000 1
W 0004 00000004 3
W 0008 00000006 1
S 1234 256 16 1234 8
S F000 256 16 F000 8
W 0000 0000000D 1
S 0700 64 16 0700 4
W 0000 00000000 1
W 0008 00000003 1
S 4000 256 16 7FFF 8
